// ==== all.f ====
+incdir+testbench
verilog/sudoku_pkg.sv
verilog/grid_store.sv
verilog/sweep_sequencer.sv
verilog/unit_mask_accumulator.sv
verilog/candidate_pruner.sv
verilog/row_streamer.sv
verilog/sudoku_solver.sv
testbench/tb_sudoku_solver.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat all.f)) testbench/tb_sudoku_model.svh
SIM  := obj_dir/Vtb_sudoku_solver

all: run

$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f all.f \
	  --top-module tb_sudoku_solver -Mdir obj_dir

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then \
	  echo "run failed, see sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== testbench/tb_sudoku_model.svh ====
`ifndef TB_SUDOKU_MODEL_SVH
`define TB_SUDOKU_MODEL_SVH

// one puzzle row per entry, one digit per nibble, column 0 in the top nibble, 0 is blank
// entries 0..8 need two sweeps and solve, entries 9..17 stall under propagation
logic [35:0] puzzle_rows [18] = '{
  36'h000000000, 36'h072195348, 36'h098342567, 36'h059761423, 36'h026803791,
  36'h013924856, 36'h061537284, 36'h087419635, 36'h045286179,
  36'h800000000, 36'h003600000, 36'h070090200, 36'h050007000, 36'h000045700,
  36'h000100030, 36'h001000068, 36'h008500010, 36'h090000400
};

row_t model_grid [GRID_N];  // worked on in place by propagate_grid

function automatic cand_t digit_mask(input logic [3:0] d);
  if (d == 4'd0) return '1;  // blank, every digit open
  return cand_t'(1) << (d - 4'd1);
endfunction

function automatic row_t digits_to_row(input logic [35:0] digits);
  row_t r;
  for (int c = 0; c < GRID_N; c++) begin
    r[c] = digit_mask(digits[35 - 4*c -: 4]);
  end
  return r;
endfunction

// repeats scan and prune sweeps on model_grid, returns 1 when every cell is settled
function automatic bit propagate_grid();
  cand_t used_row [GRID_N];
  cand_t used_col [GRID_N];
  cand_t used_box [GRID_N];
  cand_t next;
  bit    changed;
  bit    emptied;
  bit    settled;
  int    b;
  for (int sweep = 0; sweep < 1000; sweep++) begin
    for (int i = 0; i < GRID_N; i++) begin
      used_row[i] = '0;
      used_col[i] = '0;
      used_box[i] = '0;
    end
    for (int r = 0; r < GRID_N; r++) begin
      for (int c = 0; c < GRID_N; c++) begin
        b = (r / 3) * 3 + c / 3;
        if ($countones(model_grid[r][c]) == 1) begin
          used_row[r] |= model_grid[r][c];
          used_col[c] |= model_grid[r][c];
          used_box[b] |= model_grid[r][c];
        end
      end
    end
    changed = 1'b0;
    emptied = 1'b0;
    settled = 1'b1;
    for (int r = 0; r < GRID_N; r++) begin
      for (int c = 0; c < GRID_N; c++) begin
        b = (r / 3) * 3 + c / 3;
        if ($countones(model_grid[r][c]) > 1) begin  // masks stay frozen for the pass
          next = model_grid[r][c] & ~(used_row[r] | used_col[c] | used_box[b]);
          if (next != model_grid[r][c]) changed = 1'b1;
          model_grid[r][c] = next;
        end
        if (model_grid[r][c] == '0) emptied = 1'b1;
        if ($countones(model_grid[r][c]) != 1) settled = 1'b0;
      end
    end
    if (settled || emptied || !changed) return settled;
  end
  return 1'b0;
endfunction

`endif

// ==== testbench/tb_sudoku_solver.sv ====
`timescale 1ns/100ps

module tb_sudoku_solver import sudoku_pkg::*; ();

  logic       clk = 1'b0;
  logic       reset = 1'b1;
  row_write_t load = '0;
  logic       start = 1'b0;
  logic       abort = 1'b0;
  logic       credit_return = 1'b0;
  logic       busy;
  logic       solved;
  logic       stuck;
  row_out_t   stream;

  row_t   shadow [GRID_N];    // what the host has written into the grid
  row_t   exp_grid [GRID_N];
  int     errors = 0;
  int     n_pass = 0;
  int     n_fail = 0;
  int     rows_seen = 0;
  int     row_base = 0;
  int     credits_back = 0;
  int     wait_cnt = 0;
  bit     slow_credits = 1'b0;
  integer seed = 32'hba133fee;

  sudoku_solver u_dut (
    .clk, .reset, .load_i(load), .start_i(start), .abort_i(abort),
    .credit_return_i(credit_return), .busy_o(busy), .solved_o(solved),
    .stuck_o(stuck), .stream_o(stream)
  );

  `include "tb_sudoku_model.svh"

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [80:0] got, input logic [80:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: %s got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) n_pass++;
    else n_fail++;
    $display("test %-22s %s", name, (errors == errors_before) ? "passed" : "failed");
  endtask

  task automatic write_row(input int r, input row_t row, input logic [2:0] thirds);
    @(negedge clk);
    load = '{en: 1'b1, idx: IDX_W'(r), third_en: thirds, row: row};
    @(negedge clk);
    load.en = 1'b0;
  endtask

  task automatic load_puzzle(input int p);
    for (int r = 0; r < GRID_N; r++) begin
      shadow[r] = digits_to_row(puzzle_rows[p*GRID_N + r]);
      write_row(r, shadow[r], 3'b111);
    end
  endtask

  task automatic run_solve(input string name, input bit want_solved);
    int  errors_before;
    bit  exp_solved;
    errors_before = errors;
    for (int r = 0; r < GRID_N; r++) model_grid[r] = shadow[r];
    exp_solved = propagate_grid();
    for (int r = 0; r < GRID_N; r++) exp_grid[r] = model_grid[r];
    if (exp_solved != want_solved) begin
      $display("Error in %s: the puzzle table does not give the intended verdict", name);
      errors++;
    end
    row_base = rows_seen;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_value("busy_o", busy, 1);
    while (busy) @(negedge clk);
    check_value("solved_o", solved, exp_solved);
    check_value("stuck_o", stuck, !exp_solved);
    check_value("rows streamed", rows_seen - row_base, GRID_N);
    report_test(name, errors_before);
  endtask

  always @(posedge clk) begin : compare_rows
    int n;
    if (!reset && stream.valid) begin
      n = rows_seen - row_base;
      check_value("stream_o.idx", stream.idx, n);
      if (n < GRID_N) check_value("stream_o.row", stream.row, exp_grid[n]);
      rows_seen++;
      if (rows_seen - credits_back > CREDIT_MAX) begin
        $display("Error at %0d ns: more rows outstanding than the credit limit", $time);
        errors++;
      end
    end
  end

  // consumer hands one credit back per received row after a random wait
  always @(negedge clk) begin
    credit_return = 1'b0;
    if (!reset && rows_seen > credits_back) begin
      if (wait_cnt == 0) begin
        credit_return = 1'b1;
        credits_back++;
        wait_cnt = slow_credits ? 4 + ($unsigned($random(seed)) % 12)
                                : $unsigned($random(seed)) % 3;
      end else begin
        wait_cnt--;
      end
    end
  end

  initial begin
    #(5 * 200 * 20 * 40 + 100_000);  // five solves of up to 200 sweeps, plus setup
    $display("Timeout: the solver did not finish before the watchdog limit");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int   errors_before;
    row_t partial;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    errors_before = errors;
    check_value("busy_o", busy, 0);
    check_value("solved_o", solved, 0);
    check_value("stuck_o", stuck, 0);
    check_value("stream_o.valid", stream.valid, 0);
    report_test("after reset", errors_before);

    load_puzzle(0);
    run_solve("solvable puzzle", 1'b1);
    load_puzzle(1);
    run_solve("stuck puzzle", 1'b0);

    load_puzzle(0);
    partial = digits_to_row(36'h111678111);  // outer thirds must not land
    write_row(0, partial, 3'b010);
    for (int k = 0; k < BOX_N; k++) shadow[0][BOX_N + k] = partial[BOX_N + k];
    run_solve("partial write", 1'b1);

    slow_credits = 1'b1;
    load_puzzle(0);
    run_solve("back-pressure", 1'b1);
    slow_credits = 1'b0;

    load_puzzle(1);
    errors_before = errors;
    row_base = rows_seen;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    repeat (11) @(negedge clk);  // inside the first prune pass
    check_value("busy_o", busy, 1);
    abort = 1'b1;
    @(negedge clk);
    abort = 1'b0;
    check_value("busy_o", busy, 0);
    check_value("solved_o", solved, 0);
    check_value("stuck_o", stuck, 0);
    repeat (20) @(negedge clk);
    check_value("busy_o", busy, 0);
    check_value("rows streamed", rows_seen - row_base, 0);
    report_test("abort", errors_before);

    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/sudoku_solver.sv ====
`timescale 1ns/100ps

module sudoku_solver import sudoku_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  row_write_t load_i,
  input  logic       start_i,
  input  logic       abort_i,
  input  logic       credit_return_i,
  output logic       busy_o,
  output logic       solved_o,
  output logic       stuck_o,
  output row_out_t   stream_o
);

  row_write_t       grid_wr;
  row_write_t       prune_wr;
  logic [IDX_W-1:0] scan_idx;
  logic [IDX_W-1:0] stream_idx;
  row_t             scan_row;
  row_t             stream_row;
  unit_masks_t      masks;
  logic             scan_en;
  logic             prune_en;
  logic             mask_clear;
  logic             changed;
  logic             emptied;
  logic             row_solved;
  logic             stream_start;
  logic             stream_done;

  assign mask_clear = scan_en && (scan_idx == '0);  // first row of every sweep

  sweep_sequencer u_seq (
    .clk, .reset, .load_i, .start_i, .abort_i,
    .prune_wr_i(prune_wr), .changed_i(changed), .emptied_i(emptied),
    .row_solved_i(row_solved), .stream_done_i(stream_done),
    .grid_wr_o(grid_wr), .scan_idx_o(scan_idx), .scan_en_o(scan_en),
    .prune_en_o(prune_en), .busy_o, .solved_o, .stuck_o,
    .stream_start_o(stream_start)
  );

  grid_store u_grid (
    .clk, .reset, .wr_i(grid_wr),
    .rd_a_idx_i(scan_idx), .rd_b_idx_i(stream_idx),
    .rd_a_row_o(scan_row), .rd_b_row_o(stream_row)
  );

  unit_mask_accumulator u_acc (
    .clk, .reset, .scan_en_i(scan_en), .clear_i(mask_clear),
    .idx_i(scan_idx), .row_i(scan_row), .masks_o(masks)
  );

  candidate_pruner u_prune (
    .clk, .reset, .prune_en_i(prune_en), .idx_i(scan_idx), .row_i(scan_row),
    .masks_i(masks), .wr_o(prune_wr), .changed_o(changed),
    .emptied_o(emptied), .row_solved_o(row_solved)
  );

  row_streamer u_stream (
    .clk, .reset, .start_i(stream_start), .credit_return_i,
    .rd_row_i(stream_row), .rd_idx_o(stream_idx), .stream_o, .done_o(stream_done)
  );

endmodule

// ==== verilog/row_streamer.sv ====
`timescale 1ns/100ps

module row_streamer import sudoku_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             start_i,
  input  logic             credit_return_i,
  input  row_t             rd_row_i,
  output logic [IDX_W-1:0] rd_idx_o,
  output row_out_t         stream_o,
  output logic             done_o
);

  localparam int CRED_W = $clog2(CREDIT_MAX + 1);

  logic [CRED_W-1:0] credits;
  logic              active;
  logic [IDX_W-1:0]  idx;
  logic              send;

  assign send     = active && (credits != '0);  // hold the row when credits run out
  assign done_o   = send && (idx == IDX_W'(GRID_N - 1));
  assign rd_idx_o = idx;
  assign stream_o = '{valid: send, idx: idx, row: rd_row_i};

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CRED_W'(CREDIT_MAX);
      active  <= 1'b0;
      idx     <= '0;
    end else begin
      credits <= credits - CRED_W'(send) + CRED_W'(credit_return_i);
      if (start_i) begin
        active <= 1'b1;
        idx    <= '0;
      end else if (done_o) begin
        active <= 1'b0;
      end else if (send) begin
        idx <= idx + 1'b1;
      end
    end
  end

  // consumer may never hand back more credits than it was given
  a_credit_max : assert property (
    @(posedge clk) disable iff (reset)
    credits <= CRED_W'(CREDIT_MAX)
  );

endmodule

// ==== verilog/candidate_pruner.sv ====
`timescale 1ns/100ps

module candidate_pruner import sudoku_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             prune_en_i,
  input  logic [IDX_W-1:0] idx_i,
  input  row_t             row_i,
  input  unit_masks_t      masks_i,
  output row_write_t       wr_o,
  output logic             changed_o,
  output logic             emptied_o,
  output logic             row_solved_o
);

  row_t             pruned;
  logic             any_empty;
  logic             all_single;
  logic             en_q;
  logic [IDX_W-1:0] idx_q;
  row_t             row_q;

  always_comb begin
    cand_t used;
    pruned     = row_i;
    any_empty  = 1'b0;
    all_single = 1'b1;
    for (int c = 0; c < GRID_N; c++) begin
      used = masks_i.row_m[idx_i] | masks_i.col_m[c] | masks_i.box_m[box_of(idx_i, c)];
      if ($countones(row_i[c]) > 1) pruned[c] = row_i[c] & ~used;  // settled cells stay
      any_empty  = any_empty | (pruned[c] == '0);
      all_single = all_single & $onehot(pruned[c]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      en_q         <= 1'b0;
      changed_o    <= 1'b0;
      emptied_o    <= 1'b0;
      row_solved_o <= 1'b0;
    end else begin
      en_q         <= prune_en_i;
      changed_o    <= prune_en_i && (pruned != row_i);
      emptied_o    <= prune_en_i && any_empty;
      row_solved_o <= prune_en_i && all_single;
    end
  end

  always_ff @(posedge clk) begin
    if (prune_en_i) begin
      idx_q <= idx_i;
      row_q <= pruned;
    end
  end

  assign wr_o = '{en: en_q, idx: idx_q, third_en: 3'b111, row: row_q};

endmodule

// ==== verilog/unit_mask_accumulator.sv ====
`timescale 1ns/100ps

module unit_mask_accumulator import sudoku_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             scan_en_i,
  input  logic             clear_i,
  input  logic [IDX_W-1:0] idx_i,
  input  row_t             row_i,
  output unit_masks_t      masks_o
);

  unit_masks_t next_masks;

  always_comb begin
    next_masks = clear_i ? '0 : masks_o;  // clear folds into the first row
    if (scan_en_i) begin
      for (int c = 0; c < GRID_N; c++) begin
        // only settled cells name used digits
        if ($onehot(row_i[c])) begin
          next_masks.row_m[idx_i]            = next_masks.row_m[idx_i] | row_i[c];
          next_masks.col_m[c]                = next_masks.col_m[c] | row_i[c];
          next_masks.box_m[box_of(idx_i, c)] = next_masks.box_m[box_of(idx_i, c)] | row_i[c];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      masks_o <= '0;
    end else if (scan_en_i || clear_i) begin
      masks_o <= next_masks;
    end
  end

endmodule

// ==== verilog/sweep_sequencer.sv ====
`timescale 1ns/100ps

module sweep_sequencer import sudoku_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  row_write_t       load_i,
  input  logic             start_i,
  input  logic             abort_i,
  input  row_write_t       prune_wr_i,
  input  logic             changed_i,
  input  logic             emptied_i,
  input  logic             row_solved_i,
  input  logic             stream_done_i,
  output row_write_t       grid_wr_o,
  output logic [IDX_W-1:0] scan_idx_o,
  output logic             scan_en_o,
  output logic             prune_en_o,
  output logic             busy_o,
  output logic             solved_o,
  output logic             stuck_o,
  output logic             stream_start_o
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_SCAN, ST_PRUNE, ST_DRAIN, ST_VERDICT, ST_STREAM
  } state_t;

  state_t           state;
  logic [IDX_W-1:0] idx;
  logic             any_changed;
  logic             any_emptied;
  logic             all_solved;
  logic             solving;
  logic             finish;
  logic             last_row;

  assign solving  = (state != ST_IDLE) && (state != ST_STREAM);
  assign last_row = (idx == IDX_W'(GRID_N - 1));
  // no change at all means propagation has stalled
  assign finish   = all_solved | any_emptied | ~any_changed;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= ST_IDLE;
      idx         <= '0;
      any_changed <= 1'b0;
      any_emptied <= 1'b0;
      all_solved  <= 1'b1;
      solved_o    <= 1'b0;
      stuck_o     <= 1'b0;
    end else begin
      if (prune_wr_i.en) begin  // flags of each written back row
        any_changed <= any_changed | changed_i;
        any_emptied <= any_emptied | emptied_i;
        all_solved  <= all_solved & row_solved_i;
      end
      if (abort_i && solving) begin
        state <= ST_IDLE;
      end else begin
        case (state)
          ST_IDLE: begin
            if (start_i) begin
              state       <= ST_SCAN;
              idx         <= '0;
              solved_o    <= 1'b0;
              stuck_o     <= 1'b0;
              any_changed <= 1'b0;
              any_emptied <= 1'b0;
              all_solved  <= 1'b1;
            end
          end
          ST_SCAN: begin
            idx <= last_row ? '0 : idx + 1'b1;
            if (last_row) state <= ST_PRUNE;
          end
          ST_PRUNE: begin
            idx <= last_row ? '0 : idx + 1'b1;
            if (last_row) state <= ST_DRAIN;
          end
          ST_DRAIN: state <= ST_VERDICT;  // row 8 write-back
          ST_VERDICT: begin
            if (finish) begin
              state    <= ST_STREAM;
              solved_o <= all_solved;
              stuck_o  <= ~all_solved;
            end else begin
              state       <= ST_SCAN;
              any_changed <= 1'b0;
              any_emptied <= 1'b0;
              all_solved  <= 1'b1;
            end
          end
          ST_STREAM: if (stream_done_i) state <= ST_IDLE;
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  assign scan_idx_o     = idx;
  assign scan_en_o      = (state == ST_SCAN);
  assign prune_en_o     = (state == ST_PRUNE);
  assign busy_o         = (state != ST_IDLE);
  assign stream_start_o = (state == ST_VERDICT) && finish && !abort_i;
  assign grid_wr_o      = busy_o ? prune_wr_i : load_i;  // host owns the grid while idle

  a_one_pass : assert property (
    @(posedge clk) disable iff (reset)
    !(scan_en_o && prune_en_o)
  );

endmodule

// ==== verilog/grid_store.sv ====
`timescale 1ns/100ps

module grid_store import sudoku_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  row_write_t       wr_i,
  input  logic [IDX_W-1:0] rd_a_idx_i,
  input  logic [IDX_W-1:0] rd_b_idx_i,
  output row_t             rd_a_row_o,
  output row_t             rd_b_row_o
);

  row_t grid [GRID_N];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < GRID_N; r++) begin
        grid[r] <= '0;
      end
    end else if (wr_i.en) begin
      // only the selected thirds of the row are touched
      for (int t = 0; t < BOX_N; t++) begin
        if (wr_i.third_en[t]) begin
          for (int k = 0; k < BOX_N; k++) begin
            grid[wr_i.idx][t*BOX_N + k] <= wr_i.row[t*BOX_N + k];
          end
        end
      end
    end
  end

  // combinational reads, out of range rows read as empty
  assign rd_a_row_o = (rd_a_idx_i < GRID_N) ? grid[rd_a_idx_i] : '0;
  assign rd_b_row_o = (rd_b_idx_i < GRID_N) ? grid[rd_b_idx_i] : '0;

  // host and pruner writes both land here
  a_wr_idx_range : assert property (
    @(posedge clk) disable iff (reset)
    wr_i.en |-> (wr_i.idx < GRID_N)
  );

endmodule

// ==== verilog/sudoku_pkg.sv ====
package sudoku_pkg;

  localparam int GRID_N     = 9;  // cells per row, rows, digits
  localparam int BOX_N      = 3;  // box edge
  localparam int IDX_W      = 4;  // row index width
  localparam int CREDIT_MAX = 2;  // stream credits after reset

  // bit d-1 set means digit d is still possible
  typedef logic [GRID_N-1:0] cand_t;

  // column 0 in the lowest slice
  typedef cand_t [GRID_N-1:0] row_t;

  typedef struct packed {
    logic             en;
    logic [IDX_W-1:0] idx;
    logic [2:0]       third_en;  // one per group of three columns
    row_t             row;
  } row_write_t;

  typedef struct packed {
    cand_t [GRID_N-1:0] row_m;
    cand_t [GRID_N-1:0] col_m;
    cand_t [GRID_N-1:0] box_m;
  } unit_masks_t;

  typedef struct packed {
    logic             valid;
    logic [IDX_W-1:0] idx;
    row_t             row;
  } row_out_t;

  // boxes numbered left to right, top to bottom
  function automatic int box_of(input logic [IDX_W-1:0] r, input int c);
    return (int'(r) / BOX_N) * BOX_N + c / BOX_N;
  endfunction

endpackage
